//--- Bender.yml
package:
  name: rvseed

dependencies: {}

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rvseed_pkg.sv
      - hdl/if_stage.sv
      - hdl/id_stage.sv
      - hdl/ex_stage.sv
      - hdl/mem_stage.sv
      - hdl/rvseed_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_rvseed_core.sv

//--- all.f
+incdir+hdl
hdl/rvseed_pkg.sv
hdl/if_stage.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/mem_stage.sv
hdl/rvseed_core.sv
test/tb_rvseed_core.sv

//--- hdl/ex_stage.sv
// execute stage
`include "rvseed_defs.svh"

module ex_stage (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        halt_i,
    input  rvseed_pkg::id_ex_t          id_ex_i,
    input  rvseed_pkg::mem_wb_t         wb_i,
    output logic [`REG_ADDR_WIDTH-1:0]  ex_load_rd_o,
    output logic                        ex_load_o,
    output logic                        redirect_o,
    output logic [`XLEN-1:0]            redirect_pc_o,
    output rvseed_pkg::ex_mem_t         ex_mem_o
);

    localparam int unsigned SHAMT_W = $clog2(`XLEN);

    rvseed_pkg::ex_mem_t ex_mem_q;
    logic [`XLEN-1:0]    op_a;
    logic [`XLEN-1:0]    op_b;          // forwarded rs2, also store data
    logic [`XLEN-1:0]    alu_b;
    logic [`XLEN-1:0]    alu_res;
    logic                taken;

    // newest producer first
    function automatic logic [`XLEN-1:0] fwd(input logic [`REG_ADDR_WIDTH-1:0] idx,
                                             input logic [`XLEN-1:0] reg_val);
        if (idx == '0) begin
            return reg_val;
        end else if (ex_mem_q.valid && ex_mem_q.reg_we && ex_mem_q.rd == idx) begin
            return ex_mem_q.alu_res;
        end else if (wb_i.valid && wb_i.reg_we && wb_i.rd == idx) begin
            return wb_i.wdata;
        end
        return reg_val;
    endfunction

    always_comb begin
        op_a  = fwd(id_ex_i.rs1, id_ex_i.rs1_val);
        op_b  = fwd(id_ex_i.rs2, id_ex_i.rs2_val);
        alu_b = id_ex_i.use_imm ? id_ex_i.imm : op_b;
        case (id_ex_i.alu_op)
            rvseed_pkg::ALU_SUB:    alu_res = op_a - alu_b;
            rvseed_pkg::ALU_AND:    alu_res = op_a & alu_b;
            rvseed_pkg::ALU_OR:     alu_res = op_a | alu_b;
            rvseed_pkg::ALU_XOR:    alu_res = op_a ^ alu_b;
            rvseed_pkg::ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            rvseed_pkg::ALU_SLL:    alu_res = op_a << alu_b[SHAMT_W-1:0];
            rvseed_pkg::ALU_SRL:    alu_res = op_a >> alu_b[SHAMT_W-1:0];
            rvseed_pkg::ALU_PASS_B: alu_res = alu_b;
            default:                alu_res = op_a + alu_b;
        endcase
    end

    assign taken = id_ex_i.valid && (id_ex_i.is_jal
                   || (id_ex_i.is_beq && op_a == op_b)
                   || (id_ex_i.is_bne && op_a != op_b));

    assign redirect_o    = taken && !halt_i;
    assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;
    assign ex_load_o     = id_ex_i.valid && id_ex_i.is_load;
    assign ex_load_rd_o  = id_ex_i.rd;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_mem_q.valid <= 1'b0;
        end else if (!halt_i) begin
            ex_mem_q.valid      <= id_ex_i.valid;
            ex_mem_q.pc         <= id_ex_i.pc;
            ex_mem_q.alu_res    <= id_ex_i.is_jal ? id_ex_i.pc + `XLEN'd4 : alu_res;
            ex_mem_q.store_data <= op_b;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.reg_we     <= id_ex_i.reg_we;
            ex_mem_q.is_load    <= id_ex_i.is_load;
            ex_mem_q.is_store   <= id_ex_i.is_store;
            ex_mem_q.is_ebreak  <= id_ex_i.is_ebreak;
        end
    end

    assign ex_mem_o = ex_mem_q;

    // the squash in id/ex leaves a bubble behind every redirect
    redirect_one_slot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_o |-> id_ex_i.valid ##1 !redirect_o);

endmodule

//--- hdl/id_stage.sv
// decode stage and register file
`include "rvseed_defs.svh"

module id_stage (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  rvseed_pkg::if_id_t          if_id_i,
    input  logic                        redirect_i,
    input  logic                        halt_i,
    input  rvseed_pkg::mem_wb_t         wb_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  ex_load_rd_i,
    input  logic                        ex_load_i,
    output logic                        stall_o,
    output rvseed_pkg::id_ex_t          id_ex_o
);

    logic [`XLEN-1:0]    regs [2**`REG_ADDR_WIDTH];
    logic [31:0]         instr;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                legal;
    logic                use_rs1;
    logic                use_rs2;
    rvseed_pkg::opcode_e opcode;
    rvseed_pkg::id_ex_t  dec;
    rvseed_pkg::id_ex_t  id_ex_q;

    assign instr  = if_id_i.instr;
    assign opcode = rvseed_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // x0 reads zero, a same-cycle writeback wins over the array
    function automatic logic [`XLEN-1:0] rf_read(input logic [`REG_ADDR_WIDTH-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (wb_i.valid && wb_i.reg_we && wb_i.rd == idx) begin
            return wb_i.wdata;
        end
        return regs[idx];
    endfunction

    always_comb begin
        dec        = '0;
        legal      = 1'b1;
        use_rs1    = 1'b1;
        use_rs2    = 1'b0;
        dec.alu_op = rvseed_pkg::ALU_ADD;
        dec.reg_we = 1'b1;
        case (opcode)
            rvseed_pkg::OP: begin
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = rvseed_pkg::ALU_ADD;
                    10'b0100000_000: dec.alu_op = rvseed_pkg::ALU_SUB;
                    10'b0000000_001: dec.alu_op = rvseed_pkg::ALU_SLL;
                    10'b0000000_010: dec.alu_op = rvseed_pkg::ALU_SLT;
                    10'b0000000_100: dec.alu_op = rvseed_pkg::ALU_XOR;
                    10'b0000000_101: dec.alu_op = rvseed_pkg::ALU_SRL;
                    10'b0000000_110: dec.alu_op = rvseed_pkg::ALU_OR;
                    10'b0000000_111: dec.alu_op = rvseed_pkg::ALU_AND;
                    default:         legal = 1'b0;
                endcase
            end
            rvseed_pkg::OP_IMM: begin
                dec.imm     = {{(`XLEN-12){instr[31]}}, instr[31:20]};
                dec.use_imm = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = rvseed_pkg::ALU_ADD;
                    3'b010:  dec.alu_op = rvseed_pkg::ALU_SLT;
                    3'b100:  dec.alu_op = rvseed_pkg::ALU_XOR;
                    3'b110:  dec.alu_op = rvseed_pkg::ALU_OR;
                    3'b111:  dec.alu_op = rvseed_pkg::ALU_AND;
                    default: legal = 1'b0;      // shifts by immediate not supported
                endcase
            end
            rvseed_pkg::LUI: begin
                use_rs1     = 1'b0;
                dec.imm     = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
                dec.use_imm = 1'b1;
                dec.alu_op  = rvseed_pkg::ALU_PASS_B;
            end
            rvseed_pkg::LOAD: begin
                dec.imm     = {{(`XLEN-12){instr[31]}}, instr[31:20]};
                dec.use_imm = 1'b1;
                dec.is_load = 1'b1;
                legal       = (funct3 == 3'b011);   // ld only
            end
            rvseed_pkg::STORE: begin
                use_rs2      = 1'b1;
                dec.reg_we   = 1'b0;
                dec.imm      = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
                legal        = (funct3 == 3'b011);  // sd only
            end
            rvseed_pkg::BRANCH: begin
                use_rs2    = 1'b1;
                dec.reg_we = 1'b0;
                dec.imm    = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25],
                              instr[11:8], 1'b0};
                dec.is_beq = (funct3 == 3'b000);
                dec.is_bne = (funct3 == 3'b001);
                legal      = dec.is_beq || dec.is_bne;
            end
            rvseed_pkg::JAL: begin
                use_rs1    = 1'b0;
                dec.imm    = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20],
                              instr[30:21], 1'b0};
                dec.is_jal = 1'b1;
            end
            rvseed_pkg::SYSTEM: begin
                use_rs1       = 1'b0;
                dec.reg_we    = 1'b0;
                dec.is_ebreak = 1'b1;
                legal         = (instr == 32'h0010_0073);
            end
            default: begin
                use_rs1    = 1'b0;
                dec.reg_we = 1'b0;
                legal      = 1'b0;
            end
        endcase
        dec.valid   = if_id_i.valid && legal;
        dec.pc      = if_id_i.pc;
        dec.rd      = dec.reg_we ? instr[11:7] : '0;
        dec.rs1     = use_rs1 ? instr[19:15] : '0;
        dec.rs2     = use_rs2 ? instr[24:20] : '0;
        dec.rs1_val = rf_read(dec.rs1);
        dec.rs2_val = rf_read(dec.rs2);
    end

    // load result is only ready in mem/wb, hold one cycle
    assign stall_o = if_id_i.valid && ex_load_i && ex_load_rd_i != '0
                     && (ex_load_rd_i == dec.rs1 || ex_load_rd_i == dec.rs2);

    always_ff @(posedge clk_i) begin
        if (wb_i.valid && wb_i.reg_we && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.wdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_ex_q.valid <= 1'b0;
        end else if (!halt_i) begin
            id_ex_q <= dec;
            if (redirect_i || stall_o) begin
                id_ex_q.valid <= 1'b0;          // squash or bubble
            end
        end
    end

    assign id_ex_o = id_ex_q;

    // held word is still there after the stall and goes through
    stall_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i || halt_i)
        stall_o |-> if_id_i.valid ##1 (if_id_i.valid && !stall_o));

endmodule

//--- hdl/if_stage.sv
// instruction fetch stage
`include "rvseed_defs.svh"

module if_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    input  logic                 halt_i,
    input  logic                 redirect_i,
    input  logic [`XLEN-1:0]     redirect_pc_i,
    output logic [`XLEN-1:0]     imem_addr_o,
    input  logic [31:0]          imem_data_i,
    output rvseed_pkg::if_id_t   if_id_o
);

    logic [`XLEN-1:0]   pc_q;
    logic [`XLEN-1:0]   pc_d;
    rvseed_pkg::if_id_t if_id_q;

    always_comb begin
        if (halt_i) begin
            pc_d = pc_q;
        end else if (redirect_i) begin
            pc_d = redirect_pc_i;               // branch or jal target
        end else if (stall_i) begin
            pc_d = pc_q;                        // refetch same word
        end else begin
            pc_d = pc_q + `XLEN'd4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            if_id_q.valid <= 1'b0;
        end else if (!halt_i) begin
            if (redirect_i) begin
                if_id_q.valid <= 1'b0;          // wrong-path word
            end else if (!stall_i) begin
                if_id_q.valid <= 1'b1;
                if_id_q.pc    <= pc_q;
                if_id_q.instr <= imem_data_i;
            end
        end
    end

    assign imem_addr_o = pc_q;
    assign if_id_o     = if_id_q;

endmodule

//--- hdl/mem_stage.sv
// memory and writeback stage
`include "rvseed_defs.svh"

module mem_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  rvseed_pkg::ex_mem_t  ex_mem_i,
    output rvseed_pkg::mem_wb_t  mem_wb_o,
    output logic                 commit_valid_o,
    output rvseed_pkg::commit_t  commit_o,
    output logic                 halt_o
);

    localparam int unsigned DMEM_AW = $clog2(`DMEM_DEPTH);

    logic [`XLEN-1:0]    dmem [`DMEM_DEPTH];
    logic [DMEM_AW-1:0]  dmem_idx;
    logic [`XLEN-1:0]    load_data;
    logic                ebreak_commit;
    logic                halt_q;
    rvseed_pkg::mem_wb_t mem_wb_q;

    assign dmem_idx  = ex_mem_i.alu_res[3 +: DMEM_AW];  // doubleword index
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem_i.valid && ex_mem_i.is_store && !halt_o) begin
            dmem[dmem_idx] <= ex_mem_i.store_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_wb_q.valid <= 1'b0;
        end else if (!halt_o) begin
            mem_wb_q.valid     <= ex_mem_i.valid;
            mem_wb_q.pc        <= ex_mem_i.pc;
            mem_wb_q.rd        <= ex_mem_i.rd;
            mem_wb_q.reg_we    <= ex_mem_i.reg_we;
            mem_wb_q.wdata     <= ex_mem_i.is_load ? load_data : ex_mem_i.alu_res;
            mem_wb_q.is_ebreak <= ex_mem_i.is_ebreak;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            halt_q <= 1'b0;
        end else if (ebreak_commit) begin
            halt_q <= 1'b1;                     // sticky until reset
        end
    end

    assign ebreak_commit  = mem_wb_q.valid && mem_wb_q.is_ebreak && !halt_q;
    assign halt_o         = halt_q || ebreak_commit;
    assign commit_valid_o = mem_wb_q.valid && !halt_q;
    assign mem_wb_o       = mem_wb_q;

    assign commit_o.pc     = mem_wb_q.pc;
    assign commit_o.rd     = mem_wb_q.rd;
    assign commit_o.data   = (mem_wb_q.rd == '0) ? '0 : mem_wb_q.wdata;   // x0 reports zero
    assign commit_o.reg_we = mem_wb_q.reg_we;

    dword_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ex_mem_i.valid && (ex_mem_i.is_load || ex_mem_i.is_store))
        |-> ex_mem_i.alu_res[2:0] == 3'b000);

endmodule

//--- hdl/rvseed_core.sv
// rvseed five-stage core
`include "rvseed_defs.svh"

module rvseed_core (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    output logic [`XLEN-1:0]     imem_addr_o,
    input  logic [31:0]          imem_data_i,
    output logic                 commit_valid_o,
    output rvseed_pkg::commit_t  commit_o,
    output logic                 halt_o
);

    rvseed_pkg::if_id_t           if_id;
    rvseed_pkg::id_ex_t           id_ex;
    rvseed_pkg::ex_mem_t          ex_mem;
    rvseed_pkg::mem_wb_t          mem_wb;
    logic                         stall;
    logic                         redirect;
    logic [`XLEN-1:0]             redirect_pc;
    logic [`REG_ADDR_WIDTH-1:0]   ex_load_rd;
    logic                         ex_load;

    if_stage u_if_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall),
        .halt_i        (halt_o),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .if_id_o       (if_id)
    );

    id_stage u_id_stage (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .if_id_i      (if_id),
        .redirect_i   (redirect),
        .halt_i       (halt_o),
        .wb_i         (mem_wb),
        .ex_load_rd_i (ex_load_rd),
        .ex_load_i    (ex_load),
        .stall_o      (stall),
        .id_ex_o      (id_ex)
    );

    ex_stage u_ex_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .halt_i        (halt_o),
        .id_ex_i       (id_ex),
        .wb_i          (mem_wb),
        .ex_load_rd_o  (ex_load_rd),
        .ex_load_o     (ex_load),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ex_mem_o      (ex_mem)
    );

    mem_stage u_mem_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ex_mem_i       (ex_mem),
        .mem_wb_o       (mem_wb),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .halt_o         (halt_o)
    );

endmodule

//--- hdl/rvseed_defs.svh
// rvseed core constants
`ifndef RVSEED_DEFS_SVH
`define RVSEED_DEFS_SVH

`define XLEN            64
`define REG_ADDR_WIDTH  5
`define DMEM_DEPTH      64              // in doublewords
`define RESET_PC        64'h0

`endif

//--- hdl/rvseed_pkg.sv
// rvseed pipeline types
`include "rvseed_defs.svh"

package rvseed_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B                          // lui
    } alu_op_e;

    typedef struct packed {
        logic                       valid;
        logic [`XLEN-1:0]           pc;
        logic [31:0]                instr;
    } if_id_t;

    typedef struct packed {
        logic                       valid;
        logic [`XLEN-1:0]           pc;
        logic [`REG_ADDR_WIDTH-1:0] rs1;    // zero when not read
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`XLEN-1:0]           rs1_val;
        logic [`XLEN-1:0]           rs2_val;
        logic [`XLEN-1:0]           imm;
        alu_op_e                    alu_op;
        logic                       use_imm;
        logic                       reg_we;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       is_load;
        logic                       is_store;
        logic                       is_beq;
        logic                       is_bne;
        logic                       is_jal;
        logic                       is_ebreak;
    } id_ex_t;

    typedef struct packed {
        logic                       valid;
        logic [`XLEN-1:0]           pc;
        logic [`XLEN-1:0]           alu_res;    // also the memory address
        logic [`XLEN-1:0]           store_data;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       reg_we;
        logic                       is_load;
        logic                       is_store;
        logic                       is_ebreak;
    } ex_mem_t;

    typedef struct packed {
        logic                       valid;
        logic [`XLEN-1:0]           pc;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       reg_we;
        logic [`XLEN-1:0]           wdata;
        logic                       is_ebreak;
    } mem_wb_t;

    typedef struct packed {
        logic [`XLEN-1:0]           pc;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`XLEN-1:0]           data;
        logic                       reg_we;
    } commit_t;

endpackage

//--- test/rvseed_stim.hex
// header: program length in words (upper half), commit count (lower half)
// then program words from pc 0, then records: tag pc rd data reg_we
0000002500000021
00500093 FFD00113 123451B7 00208233  // pc 00
402082B3 0020C333 0030E3B3 0063F433  // pc 10
001124B3 00109533 001155B3 1231E613  // pc 20
FFF0C693 FFE12713 0FF3F793 00700813  // pc 30
010808B3 41088933 012809B3 04000A13  // pc 40
00CA3423 008A3A83 001A8B33 016A3023  // pc 50
000A3B83 00108663 00100C13 00200C13  // pc 60
00109463 00300C93 00C00D6F 00900C93  // pc 70
00A00C93 019D0DB3 00500013 00100E33  // pc 80
00100073                             // pc 90
1 00 01 5 1                 // addi x1, x0, 5
1 04 02 FFFFFFFFFFFFFFFD 1  // addi x2, x0, -3
1 08 03 12345000 1          // lui x3, 0x12345
1 0C 04 2 1                 // add x4, x1, x2
1 10 05 8 1                 // sub x5, x1, x2
1 14 06 FFFFFFFFFFFFFFF8 1  // xor x6, x1, x2
1 18 07 12345005 1          // or x7, x1, x3
1 1C 08 12345000 1          // and x8, x7, x6
1 20 09 1 1                 // slt x9, x2, x1
1 24 0A A0 1                // sll x10, x1, x1
1 28 0B 07FFFFFFFFFFFFFF 1  // srl x11, x2, x1
1 2C 0C 12345123 1          // ori x12, x3, 0x123
1 30 0D FFFFFFFFFFFFFFFA 1  // xori x13, x1, -1
1 34 0E 1 1                 // slti x14, x2, -2
1 38 0F 5 1                 // andi x15, x7, 0xff
2 3C 10 7 1                 // addi x16, x0, 7
2 40 11 E 1                 // add x17, x16, x16
2 44 12 7 1                 // sub x18, x17, x16
2 48 13 E 1                 // add x19, x16, x18
3 4C 14 40 1                // addi x20, x0, 64
3 50 00 0 0                 // sd x12, 8(x20)
3 54 15 12345123 1          // ld x21, 8(x20)
3 58 16 12345128 1          // add x22, x21, x1
3 5C 00 0 0                 // sd x22, 0(x20)
3 60 17 12345128 1          // ld x23, 0(x20)
4 64 00 0 0                 // beq x1, x1, +12
4 70 00 0 0                 // bne x1, x1, +8
4 74 19 3 1                 // addi x25, x0, 3
4 78 1A 7C 1                // jal x26, +12
4 84 1B 7F 1                // add x27, x26, x25
5 88 00 0 1                 // addi x0, x0, 5
5 8C 1C 5 1                 // add x28, x0, x1
6 90 00 0 0                 // ebreak

//--- test/tb_rvseed_core.sv
// rvseed core testbench
`include "rvseed_defs.svh"

module tb_rvseed_core;

    localparam int unsigned STIM_DEPTH = 256;
    localparam int unsigned PROG_DEPTH = 64;
    localparam int unsigned PROG_AW    = $clog2(PROG_DEPTH);
    localparam int unsigned REC_WORDS  = 5;             // tag, pc, rd, data, reg_we
    localparam logic [31:0] EBREAK     = 32'h0010_0073;

    logic                clk;
    logic                rst_n;
    logic [`XLEN-1:0]    imem_addr;
    logic [31:0]         imem_data;
    logic                commit_valid;
    rvseed_pkg::commit_t commit;
    logic                halt;

    logic [`XLEN-1:0]    stim [STIM_DEPTH];
    logic [31:0]         prog [PROG_DEPTH];
    rvseed_pkg::commit_t expected [$];
    int unsigned         tags [$];
    int unsigned         prog_len;
    int unsigned         commit_cnt;
    int unsigned         commits_seen;
    int unsigned         checks;
    int unsigned         mismatches;
    int unsigned         failures;
    int unsigned         cycles;
    int unsigned         limit;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // fetches past the program see ebreak
    assign imem_data = (imem_addr[1:0] == 2'b00 && imem_addr < 4 * PROG_DEPTH)
                       ? prog[imem_addr[2 +: PROG_AW]] : EBREAK;

    rvseed_core dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .commit_valid_o (commit_valid),
        .commit_o       (commit),
        .halt_o         (halt)
    );

    function automatic string test_name(input int unsigned tag);
        case (tag)
            1:       return "alu_ops";
            2:       return "forwarding";
            3:       return "load_use";
            4:       return "control_flow";
            5:       return "x0_zero";
            6:       return "halt";
            default: return "unknown";
        endcase
    endfunction

    task automatic load_stimulus();
        rvseed_pkg::commit_t rec;
        int unsigned         base;
        $readmemh("test/rvseed_stim.hex", stim);
        prog_len   = stim[0][63:32];
        commit_cnt = stim[0][31:0];
        assert (prog_len > 0 && prog_len <= PROG_DEPTH) else begin
            failures++;
            $display("stimulus file gives a program length of %0d words", prog_len);
        end
        for (int i = 0; i < PROG_DEPTH; i++) begin
            prog[i] = (i < prog_len) ? stim[1 + i][31:0] : EBREAK;
        end
        for (int k = 0; k < commit_cnt; k++) begin
            base       = 1 + prog_len + REC_WORDS * k;
            rec.pc     = stim[base + 1];
            rec.rd     = stim[base + 2][`REG_ADDR_WIDTH-1:0];
            rec.data   = stim[base + 3];
            rec.reg_we = stim[base + 4][0];
            tags.push_back(stim[base][31:0]);
            expected.push_back(rec);
        end
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [`XLEN-1:0] exp_val,
                               input logic [`XLEN-1:0] act_val);
        checks++;
        assert (act_val === exp_val) else begin
            mismatches++;
            $display("Error: %s commit %0d %s expected %h actual %h",
                     test, commits_seen, field, exp_val, act_val);
        end
    endtask

    task automatic compare_commit(input rvseed_pkg::commit_t rec, input string test);
        check_value(test, "pc", rec.pc, commit.pc);
        check_value(test, "rd", rec.rd, commit.rd);
        check_value(test, "data", rec.data, commit.data);
        check_value(test, "reg_we", rec.reg_we, commit.reg_we);
        check_value(test, "halt", commits_seen == commit_cnt - 1, halt);   // only on ebreak
    endtask

    // commit outputs are settled mid-cycle
    always @(negedge clk) begin
        if (rst_n && commit_valid) begin
            assert (commits_seen < commit_cnt) else begin
                failures++;
                $display("unexpected commit at pc %h after the last expected one", commit.pc);
            end
            if (commits_seen < commit_cnt) begin
                compare_commit(expected[commits_seen], test_name(tags[commits_seen]));
            end
            commits_seen++;
        end
    end

    initial begin
        rst_n        = 1'b0;
        commits_seen = 0;
        checks       = 0;
        mismatches   = 0;
        failures     = 0;
        cycles       = 0;
        load_stimulus();
        limit = 8 * commit_cnt + 40;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        while (!halt && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (halt) else begin
            failures++;
            $display("timeout: core never halted within %0d cycles", limit);
        end
        if (halt) begin
            repeat (4) begin                            // frozen, no more commits
                @(negedge clk);
                assert (halt) else begin
                    failures++;
                    $display("halt_o dropped after the ebreak committed");
                end
            end
        end
        assert (commits_seen == commit_cnt) else begin
            failures++;
            $display("core halted after %0d commits but %0d were expected",
                     commits_seen, commit_cnt);
        end
        $display("checks %0d, value mismatches %0d, other errors %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
